/* hdl/isaPkg.sv */
// RV32I subset definitions: data width, opcode and ALU enums, funct values, no-op word
`default_nettype none

package isaPkg;

    localparam int xlen = 32;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP    = 7'b0110011,
        OPIMM = 7'b0010011,
        LUI   = 7'b0110111,
        LOAD  = 7'b0000011,
        STORE = 7'b0100011
    } opcodeT;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASSB  // LUI passes the immediate
    } aluOpT;

    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Word   = 3'b010;  // LW / SW width

    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Alt  = 7'b0100000;  // SUB

    localparam logic [xlen-1:0] nopInst = 32'h0000_0013;  // ADDI x0,x0,0

endpackage

`default_nettype wire

/* hdl/memPkg.sv */
// Shared memory definitions: depth, word address width, owner enum
`default_nettype none

package memPkg;

    localparam int memDepth = 256;
    localparam int addrW    = 8;  // Word address

    typedef enum logic [1:0] {OWN_LOAD, OWN_DATA, OWN_FETCH} ownerT;

endpackage

`default_nettype wire

/* hdl/pipelineRegs.sv */
// Stage registers ifIdReg, idExReg, exMemReg and memWbReg
`timescale 1ns/100ps
`default_nettype none

module ifIdReg (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    bubble,
    input  logic [isaPkg::xlen-1:0] inst,
    input  logic [isaPkg::xlen-1:0] pc,
    output logic [isaPkg::xlen-1:0] ifIdInst,
    output logic [isaPkg::xlen-1:0] ifIdPc
);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ifIdInst <= isaPkg::nopInst;
        end else if (bubble) begin
            ifIdInst <= isaPkg::nopInst;  // No grant, no instruction
        end else begin
            ifIdInst <= inst;
        end
    end

    always_ff @(posedge clk) begin
        ifIdPc <= pc;
    end

endmodule

module idExReg (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    regWrite,
    input  logic                    memRead,
    input  logic                    memWrite,
    input  logic                    aluSrc,
    input  isaPkg::aluOpT           aluOp,
    input  logic [4:0]              rd,
    input  logic [isaPkg::xlen-1:0] rData1,
    input  logic [isaPkg::xlen-1:0] rData2,
    input  logic [isaPkg::xlen-1:0] imm32,
    output logic                    idExRegWrite,
    output logic                    idExMemRead,
    output logic                    idExMemWrite,
    output logic                    idExAluSrc,
    output isaPkg::aluOpT           idExAluOp,
    output logic [4:0]              idExRd,
    output logic [isaPkg::xlen-1:0] idExRData1,
    output logic [isaPkg::xlen-1:0] idExRData2,
    output logic [isaPkg::xlen-1:0] idExImm32
);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            idExRegWrite <= 1'b0;
            idExMemRead  <= 1'b0;
            idExMemWrite <= 1'b0;
            idExAluSrc   <= 1'b0;
            idExAluOp    <= isaPkg::ALU_ADD;
        end else begin
            idExRegWrite <= regWrite;
            idExMemRead  <= memRead;
            idExMemWrite <= memWrite;
            idExAluSrc   <= aluSrc;
            idExAluOp    <= aluOp;
        end
    end

    // Operands and destination
    always_ff @(posedge clk) begin
        idExRd     <= rd;
        idExRData1 <= rData1;
        idExRData2 <= rData2;
        idExImm32  <= imm32;
    end

endmodule

module exMemReg (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    idExRegWrite,
    input  logic                    idExMemRead,
    input  logic                    idExMemWrite,
    input  logic [4:0]              idExRd,
    input  logic [isaPkg::xlen-1:0] aluResult,
    input  logic [isaPkg::xlen-1:0] idExRData2,
    output logic                    exMemRegWrite,
    output logic                    exMemMemRead,
    output logic                    exMemMemWrite,
    output logic [4:0]              exMemRd,
    output logic [isaPkg::xlen-1:0] exMemAluResult,
    output logic [isaPkg::xlen-1:0] exMemRData2
);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            exMemRegWrite <= 1'b0;
            exMemMemRead  <= 1'b0;
            exMemMemWrite <= 1'b0;
        end else begin
            exMemRegWrite <= idExRegWrite;
            exMemMemRead  <= idExMemRead;
            exMemMemWrite <= idExMemWrite;
        end
    end

    always_ff @(posedge clk) begin
        exMemRd        <= idExRd;
        exMemAluResult <= aluResult;  // Also the data address
        exMemRData2    <= idExRData2;  // Store data
    end

    // Decode must never mark one instruction as both load and store
    assert property (@(posedge clk) disable iff (!rstN) !(exMemMemRead && exMemMemWrite));

endmodule

module memWbReg (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    exMemRegWrite,
    input  logic                    exMemMemRead,
    input  logic [4:0]              exMemRd,
    input  logic [isaPkg::xlen-1:0] exMemAluResult,
    input  logic [isaPkg::xlen-1:0] rData,
    output logic                    memWbRegWrite,
    output logic                    memWbMemRead,
    output logic [4:0]              memWbRd,
    output logic [isaPkg::xlen-1:0] memWbAluResult,
    output logic [isaPkg::xlen-1:0] memWbRData
);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            memWbRegWrite <= 1'b0;
            memWbMemRead  <= 1'b0;
        end else begin
            memWbRegWrite <= exMemRegWrite;
            memWbMemRead  <= exMemMemRead;
        end
    end

    always_ff @(posedge clk) begin
        memWbRd        <= exMemRd;
        memWbAluResult <= exMemAluResult;
        memWbRData     <= rData;  // Load data from shared memory
    end

endmodule

`default_nettype wire

/* hdl/decodeUnit.sv */
// Instruction decode: control levels, register fields, immediate
`timescale 1ns/100ps
`default_nettype none

module decodeUnit (
    input  logic [isaPkg::xlen-1:0] ifIdInst,
    output logic [4:0]              rs1,
    output logic [4:0]              rs2,
    output logic [4:0]              rd,
    output logic                    regWrite,
    output logic                    memRead,
    output logic                    memWrite,
    output logic                    aluSrc,
    output isaPkg::aluOpT           aluOp,
    output logic [isaPkg::xlen-1:0] imm32
);

    isaPkg::opcodeT opcode;
    logic [2:0]     funct3;
    logic [6:0]     funct7;
    logic           writesRd;

    assign opcode = isaPkg::opcodeT'(ifIdInst[6:0]);
    assign funct3 = ifIdInst[14:12];
    assign funct7 = ifIdInst[31:25];
    assign rs1    = ifIdInst[19:15];
    assign rs2    = ifIdInst[24:20];
    assign rd     = ifIdInst[11:7];

    always_comb begin
        writesRd = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        aluSrc   = 1'b0;
        aluOp    = isaPkg::ALU_ADD;
        imm32    = '0;
        case (opcode)
            isaPkg::OP: begin
                writesRd = 1'b1;
                if (funct3 == isaPkg::f3AddSub && funct7 == isaPkg::f7Alt) aluOp = isaPkg::ALU_SUB;
                else if (funct7 != isaPkg::f7Base) writesRd = 1'b0;  // Unknown R-type
                else if (funct3 == isaPkg::f3AddSub) aluOp = isaPkg::ALU_ADD;
                else if (funct3 == isaPkg::f3And) aluOp = isaPkg::ALU_AND;
                else if (funct3 == isaPkg::f3Or) aluOp = isaPkg::ALU_OR;
                else if (funct3 == isaPkg::f3Xor) aluOp = isaPkg::ALU_XOR;
                else writesRd = 1'b0;
            end
            isaPkg::OPIMM: begin
                writesRd = (funct3 == isaPkg::f3AddSub);  // ADDI only
                aluSrc   = 1'b1;
                imm32    = {{20{ifIdInst[31]}}, ifIdInst[31:20]};
            end
            isaPkg::LUI: begin
                writesRd = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = isaPkg::ALU_PASSB;
                imm32    = {ifIdInst[31:12], 12'b0};
            end
            isaPkg::LOAD: begin
                writesRd = (funct3 == isaPkg::f3Word);
                memRead  = (funct3 == isaPkg::f3Word);
                aluSrc   = 1'b1;
                imm32    = {{20{ifIdInst[31]}}, ifIdInst[31:20]};
            end
            isaPkg::STORE: begin
                memWrite = (funct3 == isaPkg::f3Word);
                aluSrc   = 1'b1;
                imm32    = {{20{ifIdInst[31]}}, ifIdInst[31:25], ifIdInst[11:7]};  // S-type split
            end
            default: ;  // No-op
        endcase
    end

    // Writes to x0 retire silently
    assign regWrite = writesRd && (rd != 5'd0);

endmodule

`default_nettype wire

/* hdl/regFile.sv */
// 32 x 32-bit register file with write-through reads
`timescale 1ns/100ps
`default_nettype none

module regFile (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    input  logic                    we,
    input  logic [4:0]              wAddr,
    input  logic [isaPkg::xlen-1:0] wData,
    output logic [isaPkg::xlen-1:0] rData1,
    output logic [isaPkg::xlen-1:0] rData2
);

    logic [isaPkg::xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wAddr != 5'd0) begin
            regs[wAddr] <= wData;
        end
    end

    // Bypass so decode sees a result retiring in the same cycle
    assign rData1 = (rs1 == 5'd0) ? '0 : (we && wAddr == rs1) ? wData : regs[rs1];
    assign rData2 = (rs2 == 5'd0) ? '0 : (we && wAddr == rs2) ? wData : regs[rs2];

endmodule

`default_nettype wire

/* hdl/executeUnit.sv */
// ALU with register or immediate second operand
`timescale 1ns/100ps
`default_nettype none

module executeUnit (
    input  isaPkg::aluOpT           aluOp,
    input  logic                    aluSrc,
    input  logic [isaPkg::xlen-1:0] a,
    input  logic [isaPkg::xlen-1:0] b,
    input  logic [isaPkg::xlen-1:0] imm32,
    output logic [isaPkg::xlen-1:0] aluResult
);

    logic [isaPkg::xlen-1:0] opB;

    assign opB = aluSrc ? imm32 : b;

    always_comb begin
        case (aluOp)
            isaPkg::ALU_SUB:   aluResult = a - opB;
            isaPkg::ALU_AND:   aluResult = a & opB;
            isaPkg::ALU_OR:    aluResult = a | opB;
            isaPkg::ALU_XOR:   aluResult = a ^ opB;
            isaPkg::ALU_PASSB: aluResult = opB;
            default:           aluResult = a + opB;  // ADD, ADDI, LW/SW address
        endcase
    end

endmodule

`default_nettype wire

/* hdl/fetchUnit.sv */
// Program counter advanced on each fetch grant
`timescale 1ns/100ps
`default_nettype none

module fetchUnit (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    run,
    input  logic                    fetchGrant,
    output logic [isaPkg::xlen-1:0] pc
);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (run && fetchGrant) begin
            pc <= pc + 32'd4;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* hdl/memArbiter.sv */
// Fixed-priority arbiter of loader, data access and fetch over the shared memory
`timescale 1ns/100ps
`default_nettype none

module memArbiter (
    input  logic                      progWe,
    input  logic [memPkg::addrW-1:0]  progAddr,
    input  logic [isaPkg::xlen-1:0]   progData,
    input  logic                      run,
    input  logic                      dataRead,
    input  logic                      dataWrite,
    input  logic [isaPkg::xlen-1:0]   dataAddr,
    input  logic [isaPkg::xlen-1:0]   dataWData,
    input  logic [isaPkg::xlen-1:0]   pc,
    output logic                      fetchGrant,
    output logic [memPkg::addrW-1:0]  memAddr,
    output logic                      memWe,
    output logic [isaPkg::xlen-1:0]   memWData
);

    memPkg::ownerT owner;

    always_comb begin
        if (progWe) owner = memPkg::OWN_LOAD;
        else if (dataRead || dataWrite) owner = memPkg::OWN_DATA;
        else owner = memPkg::OWN_FETCH;
    end

    assign fetchGrant = (owner == memPkg::OWN_FETCH) && run;

    always_comb begin
        case (owner)
            memPkg::OWN_LOAD: begin
                memAddr  = progAddr;
                memWe    = 1'b1;
                memWData = progData;
            end
            memPkg::OWN_DATA: begin
                memAddr  = dataAddr[memPkg::addrW+1:2];  // Byte to word address
                memWe    = dataWrite;
                memWData = dataWData;
            end
            default: begin
                memAddr  = pc[memPkg::addrW+1:2];
                memWe    = 1'b0;
                memWData = dataWData;
            end
        endcase
    end

    // Loader runs only while the core is halted
    assert property (@(posedge progWe) !run);

endmodule

`default_nettype wire

/* hdl/sharedMem.sv */
// Shared word memory, asynchronous read, synchronous write
`timescale 1ns/100ps
`default_nettype none

module sharedMem (
    input  logic                     clk,
    input  logic [memPkg::addrW-1:0] memAddr,
    input  logic                     memWe,
    input  logic [isaPkg::xlen-1:0]  memWData,
    output logic [isaPkg::xlen-1:0]  memRData
);

    logic [isaPkg::xlen-1:0] mem [memPkg::memDepth];

    always_ff @(posedge clk) begin
        if (memWe) begin
            mem[memAddr] <= memWData;
        end
    end

    assign memRData = mem[memAddr];  // Seen by fetch and the memory stage

endmodule

`default_nettype wire

/* hdl/rvCore.sv */
// Five-stage RV32I subset core with shared program and data memory
`timescale 1ns/100ps
`default_nettype none

module rvCore (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     run,
    input  logic                     progWe,
    input  logic [memPkg::addrW-1:0] progAddr,
    input  logic [isaPkg::xlen-1:0]  progData,
    output logic                     wbValid,
    output logic [4:0]               wbRd,
    output logic [isaPkg::xlen-1:0]  wbData
);

    logic [isaPkg::xlen-1:0] pc, ifIdInst, memRData, memWData;
    logic [memPkg::addrW-1:0] memAddr;
    logic fetchGrant, memWe;

    logic [4:0] rs1, rs2, rd;
    logic regWrite, memRead, memWrite, aluSrc;
    isaPkg::aluOpT aluOp;
    logic [isaPkg::xlen-1:0] imm32, rData1, rData2;

    logic idExRegWrite, idExMemRead, idExMemWrite, idExAluSrc;
    isaPkg::aluOpT idExAluOp;
    logic [4:0] idExRd;
    logic [isaPkg::xlen-1:0] idExRData1, idExRData2, idExImm32, aluResult;

    logic exMemRegWrite, exMemMemRead, exMemMemWrite;
    logic [4:0] exMemRd;
    logic [isaPkg::xlen-1:0] exMemAluResult, exMemRData2;

    logic memWbRegWrite, memWbMemRead;
    logic [4:0] memWbRd;
    logic [isaPkg::xlen-1:0] memWbAluResult, memWbRData;

    fetchUnit u_fetchUnit (.clk, .rstN, .run, .fetchGrant, .pc);

    memArbiter u_memArbiter (
        .progWe, .progAddr, .progData, .run,
        .dataRead(exMemMemRead), .dataWrite(exMemMemWrite),
        .dataAddr(exMemAluResult), .dataWData(exMemRData2), .pc,
        .fetchGrant, .memAddr, .memWe, .memWData
    );

    sharedMem u_sharedMem (.clk, .memAddr, .memWe, .memWData, .memRData);

    // Lost fetch slot becomes a bubble
    ifIdReg u_ifIdReg (
        .clk, .rstN, .bubble(!fetchGrant), .inst(memRData), .pc, .ifIdInst, .ifIdPc()
    );

    decodeUnit u_decodeUnit (
        .ifIdInst, .rs1, .rs2, .rd, .regWrite, .memRead, .memWrite, .aluSrc, .aluOp, .imm32
    );

    regFile u_regFile (
        .clk, .rstN, .rs1, .rs2, .we(memWbRegWrite), .wAddr(memWbRd), .wData(wbData),
        .rData1, .rData2
    );

    idExReg u_idExReg (
        .clk, .rstN, .regWrite, .memRead, .memWrite, .aluSrc, .aluOp, .rd,
        .rData1, .rData2, .imm32,
        .idExRegWrite, .idExMemRead, .idExMemWrite, .idExAluSrc, .idExAluOp, .idExRd,
        .idExRData1, .idExRData2, .idExImm32
    );

    executeUnit u_executeUnit (
        .aluOp(idExAluOp), .aluSrc(idExAluSrc), .a(idExRData1), .b(idExRData2),
        .imm32(idExImm32), .aluResult
    );

    exMemReg u_exMemReg (
        .clk, .rstN, .idExRegWrite, .idExMemRead, .idExMemWrite, .idExRd, .aluResult,
        .idExRData2, .exMemRegWrite, .exMemMemRead, .exMemMemWrite, .exMemRd,
        .exMemAluResult, .exMemRData2
    );

    memWbReg u_memWbReg (
        .clk, .rstN, .exMemRegWrite, .exMemMemRead, .exMemRd, .exMemAluResult,
        .rData(memRData), .memWbRegWrite, .memWbMemRead, .memWbRd, .memWbAluResult,
        .memWbRData
    );

    assign wbValid = memWbRegWrite;  // Decode already dropped rd == x0
    assign wbRd    = memWbRd;
    assign wbData  = memWbMemRead ? memWbRData : memWbAluResult;

endmodule

`default_nettype wire

/* tests/clockGen.sv */
// Testbench clock source, 40 ns period
`timescale 1ns/100ps
`default_nettype none

module clockGen (
    output logic clk
);

    localparam int halfPeriod = 20;  // ns

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

endmodule

`default_nettype wire

/* tests/tbRvCore.sv */
// Testbench of rvCore: program generator, reference model, write-back checker, watchdog
`timescale 1ns/100ps
`default_nettype none

module tbRvCore;

    localparam int dataBase  = 192;  // First word of the data area
    localparam int progLimit = 180;

    logic                     clk;
    logic                     rstN;
    logic                     run;
    logic                     progWe;
    logic [memPkg::addrW-1:0] progAddr;
    logic [31:0]              progData;
    logic                     wbValid;
    logic [4:0]               wbRd;
    logic [31:0]              wbData;

    logic [31:0] image [memPkg::memDepth];  // Memory image loaded before run
    int          lastWr [32];               // Program index of the last write per register
    int          progLen;
    logic [4:0]  expRd [$];
    logic [31:0] expVal [$];
    int          expectedCount;
    int          retired;
    int          valErrs;
    int          extraWb;
    int          genErrs;
    int          timeoutCycles;
    logic        progReady;
    int unsigned seedInit;

    clockGen u_clockGen (.clk);

    rvCore u_rvCore (
        .clk, .rstN, .run, .progWe, .progAddr, .progData, .wbValid, .wbRd, .wbData
    );

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, isaPkg::OP};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
        return {imm[11:5], rs2, rs1, isaPkg::f3Word, imm[4:0], isaPkg::STORE};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, isaPkg::LUI};
    endfunction

    function automatic logic [4:0] pickReg();
        return 5'($urandom_range(31, 1));
    endfunction

    function automatic logic [31:0] randomAlu(input logic [4:0] d, input logic [4:0] s1,
                                              input logic [4:0] s2);
        case ($urandom_range(4, 0))
            0:       return encR(isaPkg::f7Base, isaPkg::f3AddSub, d, s1, s2);
            1:       return encR(isaPkg::f7Alt, isaPkg::f3AddSub, d, s1, s2);
            2:       return encR(isaPkg::f7Base, isaPkg::f3And, d, s1, s2);
            3:       return encR(isaPkg::f7Base, isaPkg::f3Or, d, s1, s2);
            default: return encR(isaPkg::f7Base, isaPkg::f3Xor, d, s1, s2);
        endcase
    endfunction

    // Appends one instruction, padding with no-ops until its sources are four slots old
    task automatic emit(input logic [31:0] w, input logic [4:0] s1, input logic [4:0] s2,
                        input logic [4:0] d);
        while ((s1 != 5'd0 && progLen - lastWr[s1] < 4) ||
               (s2 != 5'd0 && progLen - lastWr[s2] < 4)) begin
            image[progLen] = isaPkg::nopInst;
            progLen++;
        end
        image[progLen] = w;
        if (d != 5'd0)
            lastWr[d] = progLen;
        progLen++;
    endtask

    task automatic emitAddi(input logic [4:0] d, input logic [4:0] s1, input logic [11:0] imm);
        emit(encI(imm, s1, isaPkg::f3AddSub, d, isaPkg::OPIMM), s1, 5'd0, d);
    endtask

    task automatic emitLoad(input logic [4:0] d, input logic [4:0] base, input logic [11:0] imm);
        emit(encI(imm, base, isaPkg::f3Word, d, isaPkg::LOAD), base, 5'd0, d);
    endtask

    task automatic emitStore(input logic [4:0] s2, input logic [4:0] base,
                             input logic [11:0] imm);
        emit(encS(imm, base, s2), base, s2, 5'd0);
    endtask

    task automatic buildProgram();
        logic [4:0] d;
        logic [4:0] s1;
        logic [4:0] s2;
        for (int i = 0; i < memPkg::memDepth; i++)
            image[i] = (i >= dataBase) ? $urandom : isaPkg::nopInst;
        for (int i = 0; i < 32; i++)
            lastWr[i] = -8;
        progLen = 0;
        // Immediates, negative edge values first
        emitAddi(5'd2, 5'd0, 12'hFFF);
        emitAddi(5'd4, 5'd0, 12'h800);
        for (int r = 1; r < 32; r++) begin
            if (r % 2 == 1)
                emitAddi(5'(r), 5'd0, 12'($urandom));
            else
                emit(encU(20'($urandom), 5'(r)), 5'd0, 5'd0, 5'(r));
        end
        emitAddi(5'd3, 5'd1, 12'h9C4);
        // Register ALU ops on random operands
        for (int n = 0; n < 16; n++) begin
            d  = pickReg();
            s1 = pickReg();
            s2 = pickReg();
            emit(randomAlu(d, s1, s2), s1, s2, d);
        end
        // Store then load back in reverse order
        for (int k = 0; k < 4; k++)
            emitStore(pickReg(), 5'd0, 12'(4 * (200 + 3 * k)));
        for (int k = 3; k >= 0; k--)
            emitLoad(pickReg(), 5'd0, 12'(4 * (200 + 3 * k)));
        emitLoad(pickReg(), 5'd0, 12'd0);  // Program words
        emitLoad(pickReg(), 5'd0, 12'd4);
        emitLoad(pickReg(), 5'd0, 12'(4 * 240));
        emitAddi(5'd20, 5'd0, 12'd1024);
        emitLoad(5'd21, 5'd20, 12'hFF8);  // Negative offset, word 254
        // Writes to x0, then reads of it
        emitAddi(5'd0, 5'd3, 12'd77);
        emit(encR(isaPkg::f7Base, isaPkg::f3AddSub, 5'd0, 5'd1, 5'd2), 5'd1, 5'd2, 5'd0);
        emitLoad(5'd0, 5'd0, 12'(4 * 250));
        emit(encR(isaPkg::f7Base, isaPkg::f3AddSub, 5'd9, 5'd0, 5'd0), 5'd0, 5'd0, 5'd9);
        emit(encR(isaPkg::f7Base, isaPkg::f3Or, 5'd10, 5'd0, 5'd5), 5'd0, 5'd5, 5'd10);
        // Mixed run with fetch bubbles from memory accesses
        for (int n = 0; n < 24; n++) begin
            case ($urandom_range(3, 0))
                0: begin
                    d  = pickReg();
                    s1 = pickReg();
                    s2 = pickReg();
                    emit(randomAlu(d, s1, s2), s1, s2, d);
                end
                1:       emitAddi(pickReg(), pickReg(), 12'($urandom));
                2:       emitStore(pickReg(), 5'd0, 12'(4 * $urandom_range(255, dataBase)));
                default: emitLoad(pickReg(), 5'd0, 12'(4 * $urandom_range(255, 0)));
            endcase
        end
    endtask

    // In-order ISA model over the loaded image
    function automatic void computeExpected();
        logic [31:0] mMem [memPkg::memDepth];
        logic [31:0] mRegs [32];
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] val;
        logic [7:0]  idx;
        logic        wr;
        for (int i = 0; i < memPkg::memDepth; i++)
            mMem[i] = image[i];
        for (int i = 0; i < 32; i++)
            mRegs[i] = '0;
        for (int i = 0; i < progLen; i++) begin
            w    = mMem[i];
            a    = mRegs[w[19:15]];
            b    = mRegs[w[24:20]];
            immI = {{20{w[31]}}, w[31:20]};
            wr   = 1'b1;
            val  = '0;
            case (w[6:0])
                isaPkg::OP: begin
                    case ({w[31:25], w[14:12]})
                        {isaPkg::f7Base, isaPkg::f3AddSub}: val = a + b;
                        {isaPkg::f7Alt, isaPkg::f3AddSub}:  val = a - b;
                        {isaPkg::f7Base, isaPkg::f3And}:    val = a & b;
                        {isaPkg::f7Base, isaPkg::f3Or}:     val = a | b;
                        {isaPkg::f7Base, isaPkg::f3Xor}:    val = a ^ b;
                        default:                            wr = 1'b0;
                    endcase
                end
                isaPkg::OPIMM: begin
                    val = a + immI;
                    wr  = (w[14:12] == isaPkg::f3AddSub);
                end
                isaPkg::LUI: val = {w[31:12], 12'b0};
                isaPkg::LOAD: begin
                    idx = 8'((a + immI) >> 2);
                    val = mMem[idx];
                    wr  = (w[14:12] == isaPkg::f3Word);
                end
                isaPkg::STORE: begin
                    idx = 8'((a + {{20{w[31]}}, w[31:25], w[11:7]}) >> 2);
                    if (w[14:12] == isaPkg::f3Word)
                        mMem[idx] = b;
                    wr = 1'b0;
                end
                default: wr = 1'b0;
            endcase
            if (wr && w[11:7] != 5'd0) begin
                mRegs[w[11:7]] = val;
                expRd.push_back(w[11:7]);
                expVal.push_back(val);
            end
        end
    endfunction

    task automatic compareValue(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            valErrs++;
        end
    endtask

    task automatic loadMemory();
        for (int a = 0; a < memPkg::memDepth; a++) begin
            @(posedge clk);
            progWe   <= 1'b1;
            progAddr <= a[memPkg::addrW-1:0];
            progData <= image[a];
        end
        @(posedge clk);
        progWe <= 1'b0;
    endtask

    // Each retirement pops one expected pair
    always @(negedge clk) begin : compareWb
        logic [4:0]  expDest;
        logic [31:0] expData;
        if (rstN && wbValid) begin
            if (expRd.size() == 0) begin
                $display("Unexpected write-back to x%0d at %0t ns", wbRd, $time);
                extraWb++;
            end else begin
                expDest = expRd.pop_front();
                expData = expVal.pop_front();
                compareValue($sformatf("rd of write-back %0d", retired), {27'b0, wbRd},
                             {27'b0, expDest});
                compareValue($sformatf("data of write-back %0d", retired), wbData, expData);
                retired++;
            end
        end
    end

    initial begin : watchdog
        wait (progReady);
        repeat (timeoutCycles) @(posedge clk);
        $display("Timeout after %0d cycles with %0d of %0d write-backs seen",
                 timeoutCycles, retired, expectedCount);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        seedInit  = $urandom(43775);
        rstN      = 1'b0;
        run       = 1'b0;
        progWe    = 1'b0;
        progAddr  = '0;
        progData  = '0;
        progReady = 1'b0;
        retired   = 0;
        valErrs   = 0;
        extraWb   = 0;
        genErrs   = 0;
        buildProgram();
        if (progLen > progLimit) begin
            $display("Generated program of %0d words runs into the data area", progLen);
            genErrs++;
        end
        computeExpected();
        expectedCount = expRd.size();
        timeoutCycles = 60 * progLen + memPkg::memDepth + 20;  // Includes reset and load
        progReady     = 1'b1;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        loadMemory();
        @(posedge clk);
        run <= 1'b1;
        while (retired < expectedCount)
            @(posedge clk);
        repeat (10) @(posedge clk);  // Catch trailing extra pulses
        run <= 1'b0;
        repeat (2) @(posedge clk);
        $display("Retired %0d, mismatches %0d, unexpected write-backs %0d, generator errors %0d",
                 retired, valErrs, extraWb, genErrs);
        if (valErrs + extraWb + genErrs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
hdl/isaPkg.sv
hdl/memPkg.sv
hdl/pipelineRegs.sv
hdl/decodeUnit.sv
hdl/regFile.sv
hdl/executeUnit.sv
hdl/fetchUnit.sv
hdl/memArbiter.sv
hdl/sharedMem.sv
hdl/rvCore.sv
tests/clockGen.sv
tests/tbRvCore.sv

/* run.sh */
#!/bin/sh
set -e
verilator --binary --timing --assert -j 0 --top-module tbRvCore -f tb.f -Mdir obj_dir -o simRvCore
./obj_dir/simRvCore | tee sim.log
if grep -qx "TEST OK" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
